/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= cache_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
+incdir+logic
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/cache_array.sv
logic/cache_ctrl.sv
logic/data_memory.sv
logic/cache_top.sv
tests/cache_assertions.sv
tests/cache_tb.sv

/* logic/cache_array.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module cache_array (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::idx_t        idx,
  input  cache_pkg::tag_t        tag,
  input  cache_pkg::offset_t     offset,
  input  logic [31:0]            wdata,
  input  logic                   write_word,
  input  logic                   fill,
  input  cache_pkg::cache_line_t fill_line,
  output logic                   hit,
  output logic                   dirty,
  output cache_pkg::tag_t        victim_tag,
  output cache_pkg::cache_line_t line,
  output logic [31:0]            rdata
);
  import cache_pkg::*;

  tag_t tag_mem [`CACHE_NUM_SETS];
  cache_line_t data_mem [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_bits;
  logic [`CACHE_NUM_SETS-1:0] dirty_bits;
  cache_line_t merged;

  // lookup of the selected set
  assign line = data_mem[idx];
  assign victim_tag = tag_mem[idx];
  assign hit = valid_bits[idx] && (tag_mem[idx] == tag);
  assign dirty = valid_bits[idx] && dirty_bits[idx];
  assign rdata = data_mem[idx].word[offset];

  // stored line with one word replaced
  always_comb begin
    merged = data_mem[idx];
    merged.word[offset] = wdata;
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      data_mem[idx] <= fill_line;
      tag_mem[idx] <= tag;
    end else if (write_word) begin
      data_mem[idx] <= merged;
      tag_mem[idx] <= tag;
    end
  end

  // line state bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (fill) begin
      valid_bits[idx] <= 1'b1;
      // freshly fetched line matches memory
      dirty_bits[idx] <= 1'b0;
    end else if (write_word) begin
      valid_bits[idx] <= 1'b1;
      dirty_bits[idx] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               req,
  input  logic [31:0]        addr,
  input  logic               is_write,
  input  logic [31:0]        wdata_in,
  output logic               ready,
  output logic               out_valid,
  output logic               hit_out,
  output cache_pkg::idx_t    idx,
  output cache_pkg::tag_t    tag,
  output cache_pkg::offset_t offset,
  output logic [31:0]        wdata,
  output logic               write_word,
  output logic               fill,
  input  logic               hit,
  input  logic               dirty,
  input  cache_pkg::tag_t    victim_tag,
  output mem_pkg::mem_cmd_t  mem_cmd,
  output logic [31:0]        mem_addr,
  input  logic               mem_ready,
  input  logic               mem_done
);
  import cache_pkg::*;
  import mem_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  tag_t tag_q;
  idx_t idx_q;
  offset_t offset_q;
  logic [31:0] wdata_q;
  logic write_q;
  logic miss_seen;
  logic out_valid_q;
  logic hit_q;
  logic accept;
  logic [31:0] wb_addr;
  logic [31:0] fetch_addr;

  assign ready = (state == idle);
  assign accept = req && ready;

  assign idx = idx_q;
  assign tag = tag_q;
  assign offset = offset_q;
  assign wdata = wdata_q;
  assign out_valid = out_valid_q;
  assign hit_out = hit_q;

  // line-aligned addresses for the victim and the requested line
  assign wb_addr = {victim_tag, idx_q, {(offset_w + byte_w){1'b0}}};
  assign fetch_addr = {tag_q, idx_q, {(offset_w + byte_w){1'b0}}};
  assign mem_addr = (mem_cmd == write_line) ? wb_addr : fetch_addr;

  always_comb begin
    next_state = state;
    write_word = 1'b0;
    fill = 1'b0;
    mem_cmd = none;
    case (state)
      idle: begin
        if (req) begin
          next_state = compare;
        end
      end
      compare: begin
        if (hit) begin
          write_word = write_q;
          next_state = idle;
        end else if (mem_ready) begin
          // dirty victim goes out before the new line is fetched
          if (dirty) begin
            mem_cmd = write_line;
            next_state = write_back;
          end else begin
            mem_cmd = read_line;
            next_state = allocate;
          end
        end
      end
      write_back: begin
        if (mem_done) begin
          mem_cmd = read_line;
          next_state = allocate;
        end
      end
      allocate: begin
        if (mem_done) begin
          fill = 1'b1;
          next_state = compare;
        end
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      out_valid_q <= 1'b0;
      hit_q <= 1'b0;
      miss_seen <= 1'b0;
    end else begin
      state <= next_state;
      out_valid_q <= (state == compare) && hit;
      // report the first lookup, not the replay
      if (state == compare && hit) begin
        hit_q <= !miss_seen;
      end
      if (accept) begin
        miss_seen <= 1'b0;
      end else if (state == compare && !hit) begin
        miss_seen <= 1'b1;
      end
    end
  end

  // held request
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q <= addr[31:32-tag_w];
      idx_q <= addr[idx_w+offset_w+byte_w-1:offset_w+byte_w];
      offset_q <= addr[offset_w+byte_w-1:byte_w];
      wdata_q <= wdata_in;
      write_q <= is_write;
    end
  end

endmodule

`default_nettype wire

/* logic/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_NUM_SETS 16
`define CACHE_LINE_WORDS 4

// backing memory, cycles from command to done
`define MEM_LATENCY 6

// backing memory depth in 32-bit words
`define MEM_WORDS 1024

`endif

/* logic/cache_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

  // address split: tag | index | word offset | byte
  localparam int idx_w = $clog2(`CACHE_NUM_SETS);
  localparam int offset_w = $clog2(`CACHE_LINE_WORDS);
  localparam int byte_w = 2;
  localparam int tag_w = 32 - idx_w - offset_w - byte_w;

  typedef logic [idx_w-1:0] idx_t;
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [offset_w-1:0] offset_t;

  // one line, seen flat by the memory and per word by the cache
  typedef union packed {
    logic [`CACHE_LINE_WORDS*32-1:0] flat;
    logic [`CACHE_LINE_WORDS-1:0][31:0] word;
  } cache_line_t;

  typedef enum logic [1:0] {
    idle,
    compare,
    write_back,
    allocate
  } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        req,
  input  logic [31:0] addr,
  input  logic        is_write,
  input  logic [31:0] wdata,
  output logic        ready,
  output logic        out_valid,
  output logic [31:0] rdata,
  output logic        hit
);
  import cache_pkg::*;
  import mem_pkg::*;

  // controller to array
  idx_t idx;
  tag_t tag;
  offset_t offset;
  logic [31:0] arr_wdata;
  logic write_word;
  logic fill;

  // array back to controller
  logic lookup_hit;
  logic dirty;
  tag_t victim_tag;
  cache_line_t line;

  // memory side
  mem_cmd_t mem_cmd;
  logic [31:0] mem_addr;
  logic mem_ready;
  logic mem_done;
  cache_line_t mem_rline;

  cache_ctrl ctrl (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .addr       (addr),
    .is_write   (is_write),
    .wdata_in   (wdata),
    .ready      (ready),
    .out_valid  (out_valid),
    .hit_out    (hit),
    .idx        (idx),
    .tag        (tag),
    .offset     (offset),
    .wdata      (arr_wdata),
    .write_word (write_word),
    .fill       (fill),
    .hit        (lookup_hit),
    .dirty      (dirty),
    .victim_tag (victim_tag),
    .mem_cmd    (mem_cmd),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_done   (mem_done)
  );

  cache_array array (
    .clk        (clk),
    .reset      (reset),
    .idx        (idx),
    .tag        (tag),
    .offset     (offset),
    .wdata      (arr_wdata),
    .write_word (write_word),
    .fill       (fill),
    .fill_line  (mem_rline),
    .hit        (lookup_hit),
    .dirty      (dirty),
    .victim_tag (victim_tag),
    .line       (line),
    .rdata      (rdata)
  );

  data_memory memory (
    .clk       (clk),
    .reset     (reset),
    .mem_cmd   (mem_cmd),
    .mem_addr  (mem_addr),
    .wline     (line),
    .mem_ready (mem_ready),
    .mem_done  (mem_done),
    .rline     (mem_rline)
  );

endmodule

`default_nettype wire

/* logic/data_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module data_memory (
  input  logic                   clk,
  input  logic                   reset,
  input  mem_pkg::mem_cmd_t      mem_cmd,
  input  logic [31:0]            mem_addr,
  input  cache_pkg::cache_line_t wline,
  output logic                   mem_ready,
  output logic                   mem_done,
  output cache_pkg::cache_line_t rline
);
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int word_aw = $clog2(`MEM_WORDS);
  localparam int cnt_w = $clog2(`MEM_LATENCY + 1);

  logic [31:0] words [`MEM_WORDS];
  logic busy;
  logic [cnt_w-1:0] count;
  logic start;
  logic finish;
  mem_cmd_t cmd_q;
  logic [word_aw-1:0] base_q;
  cache_line_t wline_q;

  // each word starts as its byte address with a fixed pattern
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      words[i] = (32'(i) << 2) ^ 32'h5a5a0000;
    end
  end

  assign mem_ready = !busy;
  assign start = mem_ready && (mem_cmd != none);
  // last busy cycle, access happens at its edge
  assign finish = busy && (count <= cnt_w'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      count <= '0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= finish;
      if (start) begin
        busy <= 1'b1;
        count <= cnt_w'(`MEM_LATENCY - 1);
      end else if (finish) begin
        busy <= 1'b0;
      end else if (busy) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cmd_q <= mem_cmd;
      base_q <= {mem_addr[word_aw+1:offset_w+2], {offset_w{1'b0}}};
      wline_q <= wline;
    end
    if (finish) begin
      for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
        if (cmd_q == write_line) begin
          words[base_q + word_aw'(w)] <= wline_q.word[w];
        end else begin
          rline.word[w] <= words[base_q + word_aw'(w)];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // line-wide commands toward the backing memory
  // a command is a single-cycle strobe, none when idle
  typedef enum logic [1:0] {
    none = 2'd0,
    read_line = 2'd1,
    write_line = 2'd2
  } mem_cmd_t;

endpackage

`default_nettype wire

/* tests/cache_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_assertions (
  input logic               clk,
  input logic               reset,
  input logic               req,
  input logic               ready,
  input logic               out_valid,
  input mem_pkg::mem_cmd_t  mem_cmd,
  input logic               mem_ready,
  input cache_pkg::idx_t    idx_q,
  input cache_pkg::tag_t    tag_q,
  input cache_pkg::offset_t offset_q,
  input logic [31:0]        wdata_q,
  input logic               write_q
);
  import mem_pkg::*;

  // one result strobe per request
  out_valid_single: assert property (@(posedge clk) disable iff (reset)
    out_valid |=> !out_valid)
    else $error("out_valid stayed high for two cycles");

  // memory commands are single-cycle strobes
  mem_cmd_pulse: assert property (@(posedge clk) disable iff (reset)
    (mem_cmd != none) |=> (mem_cmd == none))
    else $error("mem_cmd held longer than one cycle");

  mem_cmd_when_ready: assert property (@(posedge clk) disable iff (reset)
    (mem_cmd != none) |-> mem_ready)
    else $error("mem_cmd issued while the memory was busy");

  // an ignored req leaves the held request alone
  req_ignored_when_busy: assert property (@(posedge clk) disable iff (reset)
    (req && !ready) |=> ($stable(idx_q) && $stable(tag_q) && $stable(offset_q)
                         && $stable(wdata_q) && $stable(write_q)))
    else $error("request captured while ready was low");

endmodule

bind cache_ctrl cache_assertions chk (
  .clk       (clk),
  .reset     (reset),
  .req       (req),
  .ready     (ready),
  .out_valid (out_valid),
  .mem_cmd   (mem_cmd),
  .mem_ready (mem_ready),
  .idx_q     (idx_q),
  .tag_q     (tag_q),
  .offset_q  (offset_q),
  .wdata_q   (wdata_q),
  .write_q   (write_q)
);

`default_nettype wire

/* tests/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module cache_tb;
  localparam int reset_cycles = 10;
  localparam int num_dir = 17;
  localparam int num_rand = 60;
  localparam int op_budget = 2 * `MEM_LATENCY + 10;
  // directed, random, the back-pressure request and its quiet window
  localparam int cycle_limit = reset_cycles + (num_dir + num_rand + 2) * op_budget;

  logic clk;
  logic reset;
  logic req;
  logic [31:0] addr;
  logic is_write;
  logic [31:0] wdata;
  logic ready;
  logic out_valid;
  logic [31:0] rdata;
  logic hit;

  // directed table
  logic dir_write [num_dir];
  logic [31:0] dir_addr [num_dir];
  logic [31:0] dir_wdata [num_dir];
  logic [31:0] dir_exp [num_dir];
  logic dir_hit [num_dir];
  int dir_count;

  // shadow model
  logic [31:0] shadow_mem [`MEM_WORDS];
  logic [23:0] shadow_tag [`CACHE_NUM_SETS];
  logic shadow_valid [`CACHE_NUM_SETS];

  logic [31:0] lfsr;
  int cycle_count;
  int op_count;
  int valid_count;
  logic [31:0] got_data;
  logic got_hit;

  cache_top UUT (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .addr      (addr),
    .is_write  (is_write),
    .wdata     (wdata),
    .ready     (ready),
    .out_valid (out_valid),
    .rdata     (rdata),
    .hit       (hit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // backing memory contents before any write
  function automatic logic [31:0] mem_rule(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic add_entry(input logic w, input logic [31:0] a, input logic [31:0] d,
                           input logic [31:0] exp, input logic h);
    dir_write[dir_count] = w;
    dir_addr[dir_count] = a;
    dir_wdata[dir_count] = d;
    dir_exp[dir_count] = exp;
    dir_hit[dir_count] = h;
    dir_count++;
  endtask

  task automatic load_table;
    // first read misses and the same line then hits
    add_entry(1'b0, 32'h104, 32'h0, mem_rule(32'h104), 1'b0);
    add_entry(1'b0, 32'h10c, 32'h0, mem_rule(32'h10c), 1'b1);
    add_entry(1'b0, 32'h100, 32'h0, mem_rule(32'h100), 1'b1);
    // write hit leaves the neighbors untouched
    add_entry(1'b1, 32'h108, 32'hdeadbeef, 32'hdeadbeef, 1'b1);
    add_entry(1'b0, 32'h108, 32'h0, 32'hdeadbeef, 1'b1);
    add_entry(1'b0, 32'h104, 32'h0, mem_rule(32'h104), 1'b1);
    add_entry(1'b0, 32'h10c, 32'h0, mem_rule(32'h10c), 1'b1);
    // write miss allocates set 3
    add_entry(1'b1, 32'h234, 32'h12345678, 32'h12345678, 1'b0);
    add_entry(1'b0, 32'h238, 32'h0, mem_rule(32'h238), 1'b1);
    add_entry(1'b0, 32'h234, 32'h0, 32'h12345678, 1'b1);
    // conflict evicts the dirty line and the re-read fetches written data
    add_entry(1'b0, 32'h334, 32'h0, mem_rule(32'h334), 1'b0);
    add_entry(1'b0, 32'h234, 32'h0, 32'h12345678, 1'b0);
    add_entry(1'b0, 32'h230, 32'h0, mem_rule(32'h230), 1'b1);
    // two dirty lines fighting over set 15
    add_entry(1'b1, 32'h5f0, 32'ha5a50f0f, 32'ha5a50f0f, 1'b0);
    add_entry(1'b1, 32'h6f0, 32'hcafef00d, 32'hcafef00d, 1'b0);
    add_entry(1'b0, 32'h5f0, 32'h0, 32'ha5a50f0f, 1'b0);
    add_entry(1'b0, 32'h6f0, 32'h0, 32'hcafef00d, 1'b0);
  endtask

  task automatic start_req(input logic w, input logic [31:0] a, input logic [31:0] d);
    @(negedge clk);
    while (!ready) @(negedge clk);
    @(posedge clk);
    req <= 1'b1;
    addr <= a;
    is_write <= w;
    wdata <= d;
    @(posedge clk);
    req <= 1'b0;
    op_count++;
  endtask

  task automatic wait_result;
    @(negedge clk);
    // one request in flight keeps ready low until its result
    while (!out_valid) begin
      check_value("ready", 32'(ready), 32'd0);
      @(negedge clk);
    end
    check_value("ready", 32'(ready), 32'd1);
    got_data = rdata;
    got_hit = hit;
  endtask

  task automatic shadow_apply(input logic w, input logic [31:0] a, input logic [31:0] d,
                              output logic [31:0] exp_data, output logic exp_hit);
    logic [3:0] set;
    logic [23:0] t;
    int widx;
    set = a[7:4];
    t = a[31:8];
    widx = int'(a[11:2]);
    exp_hit = shadow_valid[set] && (shadow_tag[set] == t);
    shadow_valid[set] = 1'b1;
    shadow_tag[set] = t;
    if (w) begin
      shadow_mem[widx] = d;
    end
    exp_data = shadow_mem[widx];
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      fail_run($sformatf("timeout, run exceeded %0d cycles", cycle_limit));
    end
  end

  always @(negedge clk) begin
    if (!reset && out_valid) begin
      valid_count++;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] exp_data;
    logic exp_hit;
    logic w;
    reset <= 1'b1;
    req <= 1'b0;
    addr <= '0;
    is_write <= 1'b0;
    wdata <= '0;
    lfsr = 32'h683910ed;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      shadow_mem[i] = mem_rule(32'(i) << 2);
    end
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      shadow_valid[s] = 1'b0;
      shadow_tag[s] = '0;
    end
    load_table();
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    // idle after reset
    @(negedge clk);
    check_value("ready", 32'(ready), 32'd1);
    check_value("out_valid", 32'(out_valid), 32'd0);

    for (int i = 0; i < dir_count; i++) begin
      start_req(dir_write[i], dir_addr[i], dir_wdata[i]);
      wait_result();
      check_value("rdata", got_data, dir_exp[i]);
      check_value("hit", 32'(got_hit), 32'(dir_hit[i]));
      shadow_apply(dir_write[i], dir_addr[i], dir_wdata[i], exp_data, exp_hit);
    end

    // a write pulsed during a miss must be dropped
    shadow_apply(1'b0, 32'h7c8, 32'h0, exp_data, exp_hit);
    start_req(1'b0, 32'h7c8, 32'h0);
    @(posedge clk);
    req <= 1'b1;
    addr <= 32'h9c8;
    is_write <= 1'b1;
    wdata <= 32'hbad0bad0;
    @(posedge clk);
    req <= 1'b0;
    wait_result();
    check_value("rdata", got_data, exp_data);
    check_value("hit", 32'(got_hit), 32'(exp_hit));
    repeat (op_budget) @(negedge clk);
    assert (valid_count == op_count) else begin
      fail_run($sformatf("saw %0d out_valid pulses for %0d requests", valid_count, op_count));
    end

    // random mix over tags 2 and 6, all sets and offsets
    for (int i = 0; i < num_rand; i++) begin
      draw_bits(1, r);
      w = r[0];
      draw_bits(7, r);
      a = {20'h0, r[6] ? 4'h6 : 4'h2, r[5:2], r[1:0], 2'b00};
      d = '0;
      if (w) begin
        draw_bits(32, d);
      end
      shadow_apply(w, a, d, exp_data, exp_hit);
      start_req(w, a, d);
      wait_result();
      check_value("rdata", got_data, exp_data);
      check_value("hit", 32'(got_hit), 32'(exp_hit));
    end

    repeat (2) @(negedge clk);
    assert (valid_count == op_count) else begin
      fail_run($sformatf("saw %0d out_valid pulses for %0d requests", valid_count, op_count));
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
